//--- cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cfg_if;
   import fabric_pkg::*;

   sb_cfg_t sb_cfg;
   lut_t    lut;
   logic    we;
   logic    run;

   modport loader (
      output sb_cfg,
      output lut,
      output we,
      output run
   );

   // tile side only listens.
   modport tile (
      input  sb_cfg,
      input  lut,
      input  we,
      input  run
   );

endinterface

`default_nettype wire

//--- cfg_loader.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_loader (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cfg_valid,
   output logic                  cfg_ready,
   input  fabric_pkg::tile_idx_t cfg_tile,
   input  fabric_pkg::cfg_word_t cfg_data,
   output logic                  cfg_run,
   cfg_if.loader                 tiles [fabric_pkg::NUM_TILES]
);
   import fabric_pkg::*;

   loader_state_t        state;
   loader_state_t        state_next;
   logic                 accept;
   tile_idx_t            tile_q;
   sb_cfg_t              sb_cfg_q;
   lut_t                 lut_q;
   logic [NUM_TILES-1:0] tile_sel;
   logic [NUM_TILES-1:0] written_q;
   logic                 run_q;

   assign accept  = cfg_valid & cfg_ready;
   assign cfg_run = run_q;

   // **************************************************
   // handshake fsm
   // **************************************************

   always_comb
   begin
      state_next = state;
      case (state)
         LD_IDLE:
         begin
            if (accept)
               state_next = LD_APPLY;
         end
         LD_APPLY:
         begin
            state_next = LD_IDLE;
         end
         default:
         begin
            state_next = LD_IDLE;
         end
      endcase
   end

   // ready follows the next state, so it is low for the apply cycle.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= LD_IDLE;
         cfg_ready <= 1'b0;
         written_q <= '0;
         run_q     <= 1'b0;
      end
      else
      begin
         state     <= state_next;
         cfg_ready <= (state_next == LD_IDLE);
         if (state == LD_APPLY)
         begin
            written_q <= written_q | tile_sel;
            // run goes high with the last unwritten tile and then sticks.
            if (&(written_q | tile_sel))
               run_q <= 1'b1;
         end
      end
   end

   // accepted word and address.
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         tile_q   <= cfg_tile;
         sb_cfg_q <= cfg_data[SB_CFG_W-1:0];
         lut_q    <= cfg_data[CFG_LUT_LSB +: LUT_W];
      end
   end

   // **************************************************
   // fan out to the tiles
   // **************************************************

   for (genvar i = 0; i < NUM_TILES; i++)
   begin : g_tile
      assign tile_sel[i]     = (tile_q == tile_idx_t'(i));
      assign tiles[i].sb_cfg = sb_cfg_q;
      assign tiles[i].lut    = lut_q;
      assign tiles[i].we     = (state == LD_APPLY) & tile_sel[i];
      assign tiles[i].run    = run_q;
   end

endmodule

`default_nettype wire

//--- fabric_patterns.txt
# C tile word | S west_in east_in north_in fill_mask | E west_out east_out north_out run
# fill_mask bits 1:0 west, 3:2 east, 7:4 north, set bits take random filler
# reset state, outputs low whatever the inputs
S 0 0 0 FF
E 0 0 0 0
# tile0 alone keeps run low
C 0 A500FD00
S 3 3 0 F0
E 0 0 0 0
C 1 0000F600
E 3 3 D 1
# pure routing across both tiles
S 1 2 0 F0
E 2 1 1 1
S 2 1 0 F0
E 1 2 C 1
S 0 0 0 0
E 0 0 0 1
# tile0 lookup cell as xor, q on north_out[0], q_d on north_out[1]
C 0 000600FF
S 0 0 1 C3
S 0 0 3 C3
E 0 0 1 1
S 0 0 2 C3
E 0 0 2 1
S 0 0 0 C3
E 0 0 1 1
S 0 0 0 C3
E 0 0 2 1
# tile1 rerouted while running
S 0 1 C 0
E 0 0 4 1
C 1 0000FF5F
E 0 3 0 1
S 0 1 4 0
E 0 1 0 1

//--- fabric_pkg.sv
`default_nettype none

package fabric_pkg;

   // **************************************************
   // fabric sizes
   // **************************************************

   localparam int NUM_TILES   = 2;
   localparam int TILE_IDX_W  = $clog2(NUM_TILES);

   localparam int SEL_W       = 2;
   localparam int SB_OUTS     = 8;
   localparam int SB_CFG_W    = SEL_W * SB_OUTS;
   localparam int LUT_W       = 4;
   localparam int CFG_W       = 32;

   // lut field sits right above the switch box field.
   localparam int CFG_LUT_LSB = SB_CFG_W;

   // **************************************************
   // switch box select fields, in register order
   // **************************************************

   localparam int F_LEFT_0    = 0;
   localparam int F_LEFT_2    = 1;
   localparam int F_RIGHT_1   = 2;
   localparam int F_RIGHT_3   = 3;
   localparam int F_TOP_1     = 4;
   localparam int F_TOP_3     = 5;
   localparam int F_BOTTOM_0  = 6;
   localparam int F_BOTTOM_2  = 7;

   // **************************************************
   // types
   // **************************************************

   // codes 0..2 pick a source, code 3 ties the output low.
   typedef logic [SEL_W-1:0]      sel_t;
   typedef logic [SB_CFG_W-1:0]   sb_cfg_t;
   typedef logic [LUT_W-1:0]      lut_t;
   typedef logic [CFG_W-1:0]      cfg_word_t;
   typedef logic [TILE_IDX_W-1:0] tile_idx_t;

   typedef enum logic {
      LD_IDLE,
      LD_APPLY
   } loader_state_t;

endpackage

`default_nettype wire

//--- fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;
   import fabric_pkg::*;

   localparam int    RESET_CYCLES    = 16;
   localparam int    CYCLES_PER_LINE = 40;
   localparam int    SEED            = 61743;
   localparam string PATTERN_FILE    = "fabric_patterns.txt";

   logic                 clk;
   logic                 rst_n;
   logic                 cfg_valid;
   logic                 cfg_ready;
   tile_idx_t            cfg_tile;
   cfg_word_t            cfg_data;
   logic                 run;
   logic [1:0]           west_in;
   logic [1:0]           west_out;
   logic [1:0]           east_in;
   logic [1:0]           east_out;
   logic [3:0]           north_in;
   logic [3:0]           north_out;

   int                   cycles = 0;
   int                   cycle_limit = 0;
   int                   checks_done = 0;
   logic [NUM_TILES-1:0] tiles_written;

   tb_clock_gen clk_gen_i (
      .clk (clk)
   );

   fabric_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .cfg_tile  (cfg_tile),
      .cfg_data  (cfg_data),
      .run       (run),
      .west_in   (west_in),
      .west_out  (west_out),
      .east_in   (east_in),
      .east_out  (east_out),
      .north_in  (north_in),
      .north_out (north_out)
   );

   // **************************************************
   // reporting and checks
   // **************************************************

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("FAILED %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_tracks(
      input logic [1:0] exp_west,
      input logic [1:0] exp_east,
      input logic [3:0] exp_north
   );
      if (west_out !== exp_west)
         fail_run($sformatf("FAILED west_out: got %h expected %h", west_out, exp_west));
      if (east_out !== exp_east)
         fail_run($sformatf("FAILED east_out: got %h expected %h", east_out, exp_east));
      if (north_out !== exp_north)
         fail_run($sformatf("FAILED north_out: got %h expected %h", north_out, exp_north));
   endtask

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit)
         fail_run($sformatf("simulation ran past its limit of %0d cycles", cycle_limit));
   end

   // **************************************************
   // operations
   // **************************************************

   task automatic count_lines(output int n);
      int               fd;
      logic [8*200-1:0] text;
      n  = 0;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd != 0)
      begin
         while ($fgets(text, fd) != 0)
            n = n + 1;
         $fclose(fd);
      end
   endtask

   // masked input bits get random filler.
   task automatic apply_inputs(
      input logic [1:0] w,
      input logic [1:0] e,
      input logic [3:0] n,
      input logic [7:0] mask
   );
      logic [7:0] fill;
      fill = 8'($urandom);
      @(posedge clk);
      west_in  <= (w & ~mask[1:0]) | (fill[1:0] & mask[1:0]);
      east_in  <= (e & ~mask[3:2]) | (fill[3:2] & mask[3:2]);
      north_in <= (n & ~mask[7:4]) | (fill[7:4] & mask[7:4]);
   endtask

   task automatic check_outputs(
      input logic [1:0] w,
      input logic [1:0] e,
      input logic [3:0] n,
      input logic       r
   );
      @(negedge clk);
      check_tracks(w, e, n);
      check_flag("run", run, r);
      checks_done = checks_done + 1;
   endtask

   task automatic write_config(input tile_idx_t tile, input cfg_word_t word);
      logic ready_seen;
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_tile  <= tile;
      cfg_data  <= word;
      ready_seen = 1'b0;
      while (!ready_seen)
      begin
         @(negedge clk);
         ready_seen = cfg_ready;
         @(posedge clk);
      end
      // word taken on this edge.
      cfg_valid <= 1'b0;
      @(negedge clk);
      check_flag("cfg_ready", cfg_ready, 1'b0);
      @(posedge clk);
      @(negedge clk);
      tiles_written[tile] = 1'b1;
      if (&tiles_written && run !== 1'b1)
         fail_run("run is still low after every tile has been configured");
   endtask

   // **************************************************
   // main sequence
   // **************************************************

   initial
   begin
      int               line_count;
      int               fd;
      int               code;
      logic [7:0]       op;
      logic [31:0]      f1;
      logic [31:0]      f2;
      logic [31:0]      f3;
      logic [31:0]      f4;
      logic [8*200-1:0] rest;

      void'($urandom(SEED));
      rst_n         = 1'b0;
      cfg_valid     = 1'b0;
      cfg_tile      = '0;
      cfg_data      = '0;
      west_in       = '0;
      east_in       = '0;
      north_in      = '0;
      tiles_written = '0;

      count_lines(line_count);
      if (line_count == 0)
         fail_run("pattern file fabric_patterns.txt is missing or empty");
      cycle_limit = CYCLES_PER_LINE * line_count + RESET_CYCLES;

      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_flag("cfg_ready", cfg_ready, 1'b0);
      check_flag("run", run, 1'b0);
      @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_flag("cfg_ready", cfg_ready, 1'b1);

      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0)
         fail_run("could not open fabric_patterns.txt");
      code = $fscanf(fd, " %s", op);
      while (code == 1)
      begin
         case (op)
            "#":
            begin
               code = $fgets(rest, fd);
            end
            "C":
            begin
               code = $fscanf(fd, " %h %h", f1, f2);
               if (code != 2)
                  fail_run("configuration line in pattern file is malformed");
               write_config(tile_idx_t'(f1), cfg_word_t'(f2));
            end
            "S":
            begin
               code = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
               if (code != 4)
                  fail_run("stimulus line in pattern file is malformed");
               apply_inputs(f1[1:0], f2[1:0], f3[3:0], f4[7:0]);
            end
            "E":
            begin
               code = $fscanf(fd, " %h %h %h %h", f1, f2, f3, f4);
               if (code != 4)
                  fail_run("check line in pattern file is malformed");
               check_outputs(f1[1:0], f2[1:0], f3[3:0], f4[0]);
            end
            default:
            begin
               fail_run($sformatf("unknown operation %s in pattern file", op));
            end
         endcase
         code = $fscanf(fd, " %s", op);
      end
      $fclose(fd);

      if (checks_done == 0)
         fail_run("pattern file held no checks");
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- fabric_tile.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_tile (
   input  logic clk,
   input  logic rst_n,
   cfg_if.tile  cfg,

   output logic left_0,
   input  logic left_1,
   output logic left_2,
   input  logic left_3,

   input  logic right_0,
   output logic right_1,
   input  logic right_2,
   output logic right_3,

   input  logic top_0,
   output logic top_1,
   input  logic top_2,
   output logic top_3
);

   logic cell_a;
   logic cell_b;
   logic cell_q;
   logic cell_q_d;

   switch_box sb_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cfg      (cfg),
      .left_0   (left_0),
      .left_1   (left_1),
      .left_2   (left_2),
      .left_3   (left_3),
      .right_0  (right_0),
      .right_1  (right_1),
      .right_2  (right_2),
      .right_3  (right_3),
      .top_0    (top_0),
      .top_1    (top_1),
      .top_2    (top_2),
      .top_3    (top_3),
      .bottom_0 (cell_a),
      .bottom_1 (cell_q),
      .bottom_2 (cell_b),
      .bottom_3 (cell_q_d)
   );

   // bottom side loops through the registered cell.
   logic_cell cell_i (
      .clk   (clk),
      .rst_n (rst_n),
      .cfg   (cfg),
      .a     (cell_a),
      .b     (cell_b),
      .q     (cell_q),
      .q_d   (cell_q_d)
   );

endmodule

`default_nettype wire

//--- fabric_top.sv
`timescale 1ns/1ps
`default_nettype none

module fabric_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cfg_valid,
   output logic                  cfg_ready,
   input  fabric_pkg::tile_idx_t cfg_tile,
   input  fabric_pkg::cfg_word_t cfg_data,
   output logic                  run,
   input  logic [1:0]            west_in,
   output logic [1:0]            west_out,
   input  logic [1:0]            east_in,
   output logic [1:0]            east_out,
   input  logic [3:0]            north_in,
   output logic [3:0]            north_out
);
   import fabric_pkg::*;

   // odd tracks from tile0 into tile1.
   logic t0_to_t1_1;
   logic t0_to_t1_3;
   // even tracks from tile1 into tile0.
   logic t1_to_t0_0;
   logic t1_to_t0_2;

   cfg_if tile_cfg [NUM_TILES] ();

   cfg_loader loader_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .cfg_tile  (cfg_tile),
      .cfg_data  (cfg_data),
      .cfg_run   (run),
      .tiles     (tile_cfg)
   );

   // **************************************************
   // tile row
   // **************************************************

   fabric_tile tile0_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg     (tile_cfg[0]),
      .left_0  (west_out[0]),
      .left_1  (west_in[0]),
      .left_2  (west_out[1]),
      .left_3  (west_in[1]),
      .right_0 (t1_to_t0_0),
      .right_1 (t0_to_t1_1),
      .right_2 (t1_to_t0_2),
      .right_3 (t0_to_t1_3),
      .top_0   (north_in[0]),
      .top_1   (north_out[0]),
      .top_2   (north_in[1]),
      .top_3   (north_out[1])
   );

   fabric_tile tile1_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .cfg     (tile_cfg[1]),
      .left_0  (t1_to_t0_0),
      .left_1  (t0_to_t1_1),
      .left_2  (t1_to_t0_2),
      .left_3  (t0_to_t1_3),
      .right_0 (east_in[0]),
      .right_1 (east_out[0]),
      .right_2 (east_in[1]),
      .right_3 (east_out[1]),
      .top_0   (north_in[2]),
      .top_1   (north_out[2]),
      .top_2   (north_in[3]),
      .top_3   (north_out[3])
   );

endmodule

`default_nettype wire

//--- flist.f
fabric_pkg.sv
cfg_if.sv
cfg_loader.sv
switch_box.sv
logic_cell.sv
fabric_tile.sv
fabric_top.sv
tb_clock_gen.sv
fabric_tb.sv

//--- logic_cell.sv
`timescale 1ns/1ps
`default_nettype none

module logic_cell (
   input  logic clk,
   input  logic rst_n,
   cfg_if.tile  cfg,
   input  logic a,
   input  logic b,
   output logic q,
   output logic q_d
);
   import fabric_pkg::*;

   lut_t lut_q;

   // **************************************************
   // truth table
   // **************************************************

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lut_q <= '0;
      else if (cfg.we)
         lut_q <= cfg.lut;
   end

   // **************************************************
   // output stages
   // **************************************************

   // q_d trails q by one edge.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         q   <= 1'b0;
         q_d <= 1'b0;
      end
      else if (!cfg.run)
      begin
         q   <= 1'b0;
         q_d <= 1'b0;
      end
      else
      begin
         q   <= lut_q[{b, a}];
         q_d <= q;
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fabric testbench with verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module fabric_tb \
   -f flist.f -o fabric_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/fabric_sim 2>&1 | tee sim.log

grep -q "Test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- switch_box.sv
`timescale 1ns/1ps
`default_nettype none

module switch_box (
   input  logic clk,
   input  logic rst_n,
   cfg_if.tile  cfg,

   output logic left_0,
   input  logic left_1,
   output logic left_2,
   input  logic left_3,

   input  logic right_0,
   output logic right_1,
   input  logic right_2,
   output logic right_3,

   input  logic top_0,
   output logic top_1,
   input  logic top_2,
   output logic top_3,

   output logic bottom_0,
   input  logic bottom_1,
   output logic bottom_2,
   input  logic bottom_3
);
   import fabric_pkg::*;

   sb_cfg_t cfg_q;

   sel_t    sel_left_0;
   sel_t    sel_left_2;
   sel_t    sel_right_1;
   sel_t    sel_right_3;
   sel_t    sel_top_1;
   sel_t    sel_top_3;
   sel_t    sel_bottom_0;
   sel_t    sel_bottom_2;

   // pick one of three sources or zero for code 3.
   function automatic logic pick(
      input sel_t sel,
      input logic src_0,
      input logic src_1,
      input logic src_2
   );
      case (sel)
         2'd0:    pick = src_0;
         2'd1:    pick = src_1;
         2'd2:    pick = src_2;
         default: pick = 1'b0;
      endcase
   endfunction

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cfg_q <= '0;
      else if (cfg.we)
         cfg_q <= cfg.sb_cfg;
   end

   // **************************************************
   // select fields
   // **************************************************

   assign sel_left_0   = cfg_q[F_LEFT_0   * SEL_W +: SEL_W];
   assign sel_left_2   = cfg_q[F_LEFT_2   * SEL_W +: SEL_W];
   assign sel_right_1  = cfg_q[F_RIGHT_1  * SEL_W +: SEL_W];
   assign sel_right_3  = cfg_q[F_RIGHT_3  * SEL_W +: SEL_W];
   assign sel_top_1    = cfg_q[F_TOP_1    * SEL_W +: SEL_W];
   assign sel_top_3    = cfg_q[F_TOP_3    * SEL_W +: SEL_W];
   assign sel_bottom_0 = cfg_q[F_BOTTOM_0 * SEL_W +: SEL_W];
   assign sel_bottom_2 = cfg_q[F_BOTTOM_2 * SEL_W +: SEL_W];

   // **************************************************
   // output muxes
   // **************************************************

   // even tracks run left and down.
   assign left_0   = cfg.run & pick(sel_left_0,   right_0,  top_0,  bottom_1);
   assign left_2   = cfg.run & pick(sel_left_2,   right_2,  top_2,  bottom_3);
   assign bottom_0 = cfg.run & pick(sel_bottom_0, top_0,    left_1, right_0);
   assign bottom_2 = cfg.run & pick(sel_bottom_2, top_2,    left_3, right_2);

   // odd tracks run right and up.
   assign right_1  = cfg.run & pick(sel_right_1,  left_1,   top_0,  bottom_1);
   assign right_3  = cfg.run & pick(sel_right_3,  left_3,   top_2,  bottom_3);
   assign top_1    = cfg.run & pick(sel_top_1,    bottom_1, left_1, right_0);
   assign top_3    = cfg.run & pick(sel_top_3,    bottom_3, left_3, right_2);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   // 40 ns period.
   localparam int HALF_PERIOD_NS = 20;

   initial
   begin
      clk = 1'b0;
      forever
         #(HALF_PERIOD_NS) clk = ~clk;
   end

endmodule

`default_nettype wire
